// ==== div_pkg.sv ====
package div_pkg;

    // operand width of the divider
    localparam int WIDTH = 16;

    // step counter must reach WIDTH
    localparam int COUNT_W = 5;

    // controller state encoding
    localparam int STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE   = 2'd0;
    localparam logic [STATE_W-1:0] ST_LOAD   = 2'd1;
    localparam logic [STATE_W-1:0] ST_RUN    = 2'd2;
    localparam logic [STATE_W-1:0] ST_FINISH = 2'd3;

    // remainder:quotient shift register, shifted whole, read by field
    typedef union packed {
        logic [2*WIDTH:0] word;
        struct packed {
            // partial remainder, top bit is the sign
            logic [WIDTH:0]   a;
            logic [WIDTH-1:0] q;
        } f;
    } div_aq_u;

endpackage

// ==== div_regs_pkg.sv ====
package div_regs_pkg;

    // apb bus widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // register offsets
    localparam logic [ADDR_W-1:0] ADDR_DIVIDEND  = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_DIVISOR   = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_CTRL      = 8'h08;
    localparam logic [ADDR_W-1:0] ADDR_STATUS    = 8'h0C;
    localparam logic [ADDR_W-1:0] ADDR_QUOTIENT  = 8'h10;
    localparam logic [ADDR_W-1:0] ADDR_REMAINDER = 8'h14;

    // ctrl register bits
    localparam int CTRL_START_BIT = 0;

    // status register bits
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

// ==== div_op_if.sv ====
interface div_op_if;

    // operands held by the register block
    logic [div_pkg::WIDTH-1:0] dividend;
    logic [div_pkg::WIDTH-1:0] divisor;

    // handshake
    logic start;
    logic busy;
    logic done;

    // results from the datapath
    logic [div_pkg::WIDTH-1:0] quotient;
    logic [div_pkg::WIDTH-1:0] remainder;

    modport host (
        output dividend,
        output divisor,
        output start,
        input  busy,
        input  done,
        input  quotient,
        input  remainder
    );

    modport ctrl (
        input  start,
        output busy,
        output done
    );

    modport dp (
        input  dividend,
        input  divisor,
        output quotient,
        output remainder
    );

endinterface

// ==== div_datapath.sv ====
module div_datapath (
    input  logic    clk,
    input  logic    n_rst,

    // from the controller
    input  logic    load,
    input  logic    step,

    // to the controller
    output logic    last,

    div_op_if.dp    op
);

    div_pkg::div_aq_u aq_reg;
    div_pkg::div_aq_u aq_shift;
    div_pkg::div_aq_u aq_next;

    logic [div_pkg::WIDTH-1:0]   divisor_reg;
    logic [div_pkg::WIDTH:0]     trial;
    logic [div_pkg::COUNT_W-1:0] count;

    // divisor is captured once per operation
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            divisor_reg <= '0;
        end else if (load) begin
            divisor_reg <= op.divisor;
        end
    end

    // shift left, then trial subtract on the remainder field
    always_comb begin
        aq_shift.word = aq_reg.word << 1;
        trial         = aq_shift.f.a - {1'b0, divisor_reg};
    end

    // restore when the trial went negative
    always_comb begin
        aq_next = aq_shift;
        if (!trial[div_pkg::WIDTH]) begin
            aq_next.f.a    = trial;
            aq_next.f.q[0] = 1'b1;
        end
    end

    // remainder:quotient register
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            aq_reg.word <= '0;
        end else if (load) begin
            aq_reg.f.a <= '0;
            aq_reg.f.q <= op.dividend;
        end else if (step) begin
            aq_reg <= aq_next;
        end
    end

    // step counter
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else if (load) begin
            count <= '0;
        end else if (step) begin
            count <= count + div_pkg::COUNT_W'(1);
        end
    end

    assign last = (count == div_pkg::COUNT_W'(div_pkg::WIDTH));

    // results stay put until the next load
    assign op.quotient  = aq_reg.f.q;
    assign op.remainder = aq_reg.f.a[div_pkg::WIDTH-1:0];

endmodule

// ==== div_controller.sv ====
module div_controller (
    input  logic    clk,
    input  logic    n_rst,

    // from the datapath
    input  logic    last,

    // to the datapath
    output logic    load,
    output logic    step,

    div_op_if.ctrl  op
);

    logic [div_pkg::STATE_W-1:0] state;
    logic [div_pkg::STATE_W-1:0] state_next;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= div_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // next state
    always_comb begin
        state_next = state;
        case (state)
            div_pkg::ST_IDLE: begin
                // start is only seen here, so a start while busy is dropped
                if (op.start) begin
                    state_next = div_pkg::ST_LOAD;
                end
            end
            div_pkg::ST_LOAD: begin
                state_next = div_pkg::ST_RUN;
            end
            div_pkg::ST_RUN: begin
                if (last) begin
                    state_next = div_pkg::ST_FINISH;
                end
            end
            div_pkg::ST_FINISH: begin
                state_next = div_pkg::ST_IDLE;
            end
            default: begin
                state_next = div_pkg::ST_IDLE;
            end
        endcase
    end

    // outputs decoded from the state
    assign load = (state == div_pkg::ST_LOAD);

    // no step once the counter has reached the width
    assign step = (state == div_pkg::ST_RUN) && !last;

    assign op.busy = load || (state == div_pkg::ST_RUN);
    assign op.done = (state == div_pkg::ST_FINISH);

endmodule

// ==== div_apb_regs.sv ====
module div_apb_regs (
    input  logic                              clk,
    input  logic                              n_rst,

    // apb slave
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [div_regs_pkg::ADDR_W-1:0]   paddr,
    input  logic [div_regs_pkg::DATA_W-1:0]   pwdata,
    output logic [div_regs_pkg::DATA_W-1:0]   prdata,
    output logic                              pready,
    output logic                              pslverr,

    div_op_if.host                            op
);

    logic                        access;
    logic                        wr_en;
    logic                        addr_hit;
    logic                        addr_ro;
    logic                        start_reg;
    logic                        done_bit;
    logic [div_pkg::WIDTH-1:0]   dividend_reg;
    logic [div_pkg::WIDTH-1:0]   divisor_reg;

    // every access completes in its access phase
    assign pready = 1'b1;
    assign access = psel && penable;

    // address decode
    always_comb begin
        addr_hit = 1'b0;
        addr_ro  = 1'b0;
        case (paddr)
            div_regs_pkg::ADDR_DIVIDEND,
            div_regs_pkg::ADDR_DIVISOR,
            div_regs_pkg::ADDR_CTRL: begin
                addr_hit = 1'b1;
            end
            div_regs_pkg::ADDR_STATUS,
            div_regs_pkg::ADDR_QUOTIENT,
            div_regs_pkg::ADDR_REMAINDER: begin
                addr_hit = 1'b1;
                addr_ro  = 1'b1;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    assign pslverr = access && (!addr_hit || (pwrite && addr_ro));
    assign wr_en   = access && pwrite && addr_hit && !addr_ro;

    // operand registers
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            dividend_reg <= '0;
            divisor_reg  <= '0;
        end else if (wr_en) begin
            if (paddr == div_regs_pkg::ADDR_DIVIDEND) begin
                dividend_reg <= pwdata[div_pkg::WIDTH-1:0];
            end
            if (paddr == div_regs_pkg::ADDR_DIVISOR) begin
                divisor_reg <= pwdata[div_pkg::WIDTH-1:0];
            end
        end
    end

    // start pulse in the cycle after the ctrl write
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            start_reg <= 1'b0;
        end else begin
            start_reg <= wr_en && (paddr == div_regs_pkg::ADDR_CTRL)
                         && pwdata[div_regs_pkg::CTRL_START_BIT];
        end
    end

    // sticky done, cleared by a start the engine accepts
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            done_bit <= 1'b0;
        end else if (op.done) begin
            done_bit <= 1'b1;
        end else if (start_reg && !op.busy) begin
            done_bit <= 1'b0;
        end
    end

    assign op.dividend = dividend_reg;
    assign op.divisor  = divisor_reg;
    assign op.start    = start_reg;

    // read mux, ctrl and unmapped offsets read zero
    always_comb begin
        prdata = '0;
        case (paddr)
            div_regs_pkg::ADDR_DIVIDEND: begin
                prdata[div_pkg::WIDTH-1:0] = dividend_reg;
            end
            div_regs_pkg::ADDR_DIVISOR: begin
                prdata[div_pkg::WIDTH-1:0] = divisor_reg;
            end
            div_regs_pkg::ADDR_STATUS: begin
                prdata[div_regs_pkg::STATUS_BUSY_BIT] = op.busy;
                prdata[div_regs_pkg::STATUS_DONE_BIT] = done_bit;
            end
            div_regs_pkg::ADDR_QUOTIENT: begin
                prdata[div_pkg::WIDTH-1:0] = op.quotient;
            end
            div_regs_pkg::ADDR_REMAINDER: begin
                prdata[div_pkg::WIDTH-1:0] = op.remainder;
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

// ==== div_top.sv ====
module div_top (
    input  logic                              clk,
    input  logic                              n_rst,

    // apb slave
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [div_regs_pkg::ADDR_W-1:0]   paddr,
    input  logic [div_regs_pkg::DATA_W-1:0]   pwdata,
    output logic [div_regs_pkg::DATA_W-1:0]   prdata,
    output logic                              pready,
    output logic                              pslverr
);

    // controller to datapath
    logic load;
    logic step;
    logic last;

    // register block to engine
    div_op_if op ();

    div_apb_regs u_regs (
        .clk     (clk),
        .n_rst   (n_rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .op      (op.host)
    );

    div_controller u_ctrl (
        .clk   (clk),
        .n_rst (n_rst),
        .last  (last),
        .load  (load),
        .step  (step),
        .op    (op.ctrl)
    );

    div_datapath u_dp (
        .clk   (clk),
        .n_rst (n_rst),
        .load  (load),
        .step  (step),
        .last  (last),
        .op    (op.dp)
    );

endmodule

// ==== tb_div_top.sv ====
module tb_div_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int POLL_LIMIT   = 100;
    localparam int NUM_RANDOM   = 24;

    localparam logic [div_regs_pkg::ADDR_W-1:0] UNMAPPED_ADDR = 8'h20;
    localparam logic [31:0] START_CMD   = 32'd1 << div_regs_pkg::CTRL_START_BIT;
    localparam logic [31:0] STATUS_BUSY = 32'd1 << div_regs_pkg::STATUS_BUSY_BIT;
    localparam logic [31:0] STATUS_DONE = 32'd1 << div_regs_pkg::STATUS_DONE_BIT;

    logic                            clk;
    logic                            n_rst;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [div_regs_pkg::ADDR_W-1:0] paddr;
    logic [div_regs_pkg::DATA_W-1:0] pwdata;
    logic [div_regs_pkg::DATA_W-1:0] prdata;
    logic                            pready;
    logic                            pslverr;

    int seed;

    div_top UUT (
        .clk     (clk),
        .n_rst   (n_rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            abort_run();
        end
    endtask

    // a zero divisor gives all ones and the dividend back
    function automatic logic [15:0] ref_quotient(input logic [15:0] a, input logic [15:0] b);
        if (b == 16'h0) begin
            return 16'hFFFF;
        end else begin
            return a / b;
        end
    endfunction

    function automatic logic [15:0] ref_remainder(input logic [15:0] a, input logic [15:0] b);
        if (b == 16'h0) begin
            return a;
        end else begin
            return a % b;
        end
    endfunction

    // one apb transfer with setup and access phase driven on falling edges
    task automatic apb_access(input logic is_write, input logic [div_regs_pkg::ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        // the slave never inserts wait states
        check_value(32'(pready), 32'd1, $sformatf("pready in access to 0x%0h", addr));
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [div_regs_pkg::ADDR_W-1:0] addr,
                             input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value(32'(err), 32'd0, $sformatf("pslverr on write to 0x%0h", addr));
    endtask

    task automatic apb_read(input logic [div_regs_pkg::ADDR_W-1:0] addr,
                            output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_value(32'(err), 32'd0, $sformatf("pslverr on read of 0x%0h", addr));
    endtask

    task automatic load_operands(input logic [15:0] a, input logic [15:0] b);
        apb_write(div_regs_pkg::ADDR_DIVIDEND, 32'(a));
        apb_write(div_regs_pkg::ADDR_DIVISOR, 32'(b));
    endtask

    // poll status until the sticky done bit shows up
    task automatic wait_for_done();
        logic [31:0] status;
        int          polls;
        polls = 0;
        apb_read(div_regs_pkg::ADDR_STATUS, status);
        while (!status[div_regs_pkg::STATUS_DONE_BIT]) begin
            if (polls == POLL_LIMIT) begin
                $display("Timed out waiting for the done bit in STATUS");
                abort_run();
            end
            polls++;
            apb_read(div_regs_pkg::ADDR_STATUS, status);
        end
    endtask

    task automatic check_results(input logic [15:0] exp_q, input logic [15:0] exp_r,
                                 input string label);
        logic [31:0] rdata;
        apb_read(div_regs_pkg::ADDR_QUOTIENT, rdata);
        check_value(rdata, 32'(exp_q), {label, " quotient"});
        apb_read(div_regs_pkg::ADDR_REMAINDER, rdata);
        check_value(rdata, 32'(exp_r), {label, " remainder"});
    endtask

    task automatic run_division(input logic [15:0] a, input logic [15:0] b,
                                input logic [15:0] exp_q, input logic [15:0] exp_r,
                                input string label);
        load_operands(a, b);
        apb_write(div_regs_pkg::ADDR_CTRL, START_CMD);
        wait_for_done();
        check_results(exp_q, exp_r, label);
    endtask

    initial begin
        int          fd;
        int          n;
        int          vectors;
        int          shift;
        string       line;
        logic [15:0] t_a;
        logic [15:0] t_b;
        logic [15:0] t_q;
        logic [15:0] t_r;
        logic [31:0] rdata;
        logic        err;

        seed    = 54121;
        n_rst   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        n_rst = 1'b1;

        // reset values
        apb_read(div_regs_pkg::ADDR_STATUS, rdata);
        check_value(rdata, 32'd0, "STATUS after reset");
        check_results(16'h0, 16'h0, "after reset");

        fd = $fopen("div_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open div_trace.txt");
            abort_run();
        end
        vectors = 0;
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h\n", t_a, t_b, t_q, t_r);
            if (n == 4) begin
                vectors++;
                // the trace itself has to follow the divide rule
                check_value(32'(t_q), 32'(ref_quotient(t_a, t_b)),
                            $sformatf("trace vector %0d quotient entry", vectors));
                check_value(32'(t_r), 32'(ref_remainder(t_a, t_b)),
                            $sformatf("trace vector %0d remainder entry", vectors));
                run_division(t_a, t_b, t_q, t_r,
                             $sformatf("trace vector %0d (%h / %h)", vectors, t_a, t_b));
            end else if (n > 0) begin
                $display("Malformed line in div_trace.txt after vector %0d", vectors);
                abort_run();
            end else begin
                // comment line
                n = $fgets(line, fd);
            end
        end
        $fclose(fd);
        if (vectors == 0) begin
            $display("No vectors were read from div_trace.txt");
            abort_run();
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            t_a   = 16'($random(seed));
            t_b   = 16'($random(seed));
            // narrow some divisors so large quotients show up too
            shift = {$random(seed)} % 16;
            t_b   = t_b >> shift;
            run_division(t_a, t_b, ref_quotient(t_a, t_b), ref_remainder(t_a, t_b),
                         $sformatf("random vector %0d (%h / %h)", i, t_a, t_b));
        end

        // sticky done is cleared when the next start is taken
        apb_read(div_regs_pkg::ADDR_STATUS, rdata);
        check_value(rdata, STATUS_DONE, "STATUS after completion");
        load_operands(16'hC350, 16'h00FA);
        apb_write(div_regs_pkg::ADDR_CTRL, START_CMD);
        apb_read(div_regs_pkg::ADDR_STATUS, rdata);
        check_value(rdata, STATUS_BUSY, "STATUS once start is accepted");

        // new operands and a second start while the engine is busy
        load_operands(16'hFFFF, 16'h0010);
        apb_write(div_regs_pkg::ADDR_CTRL, START_CMD);
        wait_for_done();
        check_results(ref_quotient(16'hC350, 16'h00FA), ref_remainder(16'hC350, 16'h00FA),
                      "division with writes during busy");
        apb_read(div_regs_pkg::ADDR_STATUS, rdata);
        check_value(rdata, STATUS_DONE, "STATUS after the dropped start");
        apb_write(div_regs_pkg::ADDR_CTRL, START_CMD);
        wait_for_done();
        check_results(ref_quotient(16'hFFFF, 16'h0010), ref_remainder(16'hFFFF, 16'h0010),
                      "division with the later operands");

        // bus errors
        apb_access(1'b0, UNMAPPED_ADDR, 32'd0, rdata, err);
        check_value(32'(err), 32'd1, "pslverr on read of unmapped offset");
        check_value(rdata, 32'd0, "read data of unmapped offset");
        apb_access(1'b1, UNMAPPED_ADDR, 32'hA5A5, rdata, err);
        check_value(32'(err), 32'd1, "pslverr on write to unmapped offset");
        apb_access(1'b1, div_regs_pkg::ADDR_QUOTIENT, 32'h1234, rdata, err);
        check_value(32'(err), 32'd1, "pslverr on write to QUOTIENT");
        check_results(ref_quotient(16'hFFFF, 16'h0010), ref_remainder(16'hFFFF, 16'h0010),
                      "results after a rejected write");
        apb_read(div_regs_pkg::ADDR_CTRL, rdata);
        check_value(rdata, 32'd0, "CTRL read");

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== div_trace.txt ====
# columns: dividend divisor quotient remainder, all 16-bit hex
# divisor 0000 gives quotient ffff and the dividend as remainder
0064 000A 000A 0000
0007 0002 0003 0001
FFFF 0001 FFFF 0000
FFFF FFFF 0001 0000
0000 0005 0000 0000
1234 0000 FFFF 1234
0000 0000 FFFF 0000
FFFF 0000 FFFF FFFF
0005 0007 0000 0005
8000 0002 4000 0000
FFFE FFFF 0000 FFFE
FFFF 8000 0001 7FFF
03E8 0007 008E 0006
2710 0064 0064 0000
2710 0003 0D05 0001
1000 0010 0100 0000
1001 0010 0100 0001
ABCD 0100 00AB 00CD
ABCD 0010 0ABC 000D
00FF 000F 0011 0000
0100 000F 0011 0001
7FFF 0002 3FFF 0001
C350 00FA 00C8 0000
C351 00FA 00C8 0001
0001 0001 0001 0000
8000 8001 0000 8000
FFFF 0100 00FF 00FF
0BB8 0007 01AC 0004

// ==== project.f ====
div_pkg.sv
div_regs_pkg.sv
div_op_if.sv
div_datapath.sv
div_controller.sv
div_apb_regs.sv
div_top.sv
tb_div_top.sv
